// ==== source/pipe_ctrl_pkg.sv ====
package pipe_ctrl_pkg;

    // register number, r0 never creates a hazard
    typedef logic [4:0] reg_addr_t;

    // tag rides along with the instruction up to retirement
    typedef logic [7:0] inst_tag_t;

    // control event carried by a descriptor
    typedef logic [1:0] pipe_event_t;

    localparam pipe_event_t EV_NONE    = 2'd0;
    localparam pipe_event_t EV_JUMP    = 2'd1; // resolves in D
    localparam pipe_event_t EV_MISPRED = 2'd2; // resolves in E
    localparam pipe_event_t EV_EXCEPT  = 2'd3; // resolves in M

    // divide unit control
    typedef enum logic [1:0] {
        DIV_IDLE,
        DIV_BUSY,
        DIV_DONE
    } div_state_t;

    // cycles E_alu_stall stays high for one divide
    localparam int DIV_LATENCY = 4;

    // fetch buffer entries
    localparam int FETCH_DEPTH = 2;

    // edges from acceptance to retire_valid, hazard free
    // 1 buffer + F D E M W register hops (5) ... retire_port adds the last one
    localparam int RETIRE_LATENCY = 6;

    // retired instruction count
    typedef logic [15:0] retire_count_t;

endpackage

// ==== source/fetch_buffer.sv ====
`timescale 1ns/100ps
module fetch_buffer (
    input  logic                        clk,
    input  logic                        reset,
    // stream side
    input  logic                        in_valid,
    output logic                        in_ready,
    input  pipe_ctrl_pkg::inst_tag_t    in_tag,
    input  pipe_ctrl_pkg::reg_addr_t    in_rs,
    input  pipe_ctrl_pkg::reg_addr_t    in_rt,
    input  logic                        in_read_rs,
    input  logic                        in_read_rt,
    input  pipe_ctrl_pkg::reg_addr_t    in_waddr,
    input  logic                        in_mem_to_reg,
    input  logic                        in_is_div,
    input  pipe_ctrl_pkg::pipe_event_t  in_event,
    // head towards F
    output logic                        head_valid,
    output pipe_ctrl_pkg::inst_tag_t    head_tag,
    output pipe_ctrl_pkg::reg_addr_t    head_rs,
    output pipe_ctrl_pkg::reg_addr_t    head_rt,
    output logic                        head_read_rs,
    output logic                        head_read_rt,
    output pipe_ctrl_pkg::reg_addr_t    head_waddr,
    output logic                        head_mem_to_reg,
    output logic                        head_is_div,
    output pipe_ctrl_pkg::pipe_event_t  head_event,
    input  logic                        f_take        // F consumes the head this cycle
);
    import pipe_ctrl_pkg::*;

    // one storage array per descriptor field
    inst_tag_t   tag_q       [FETCH_DEPTH];
    reg_addr_t   rs_q        [FETCH_DEPTH];
    reg_addr_t   rt_q        [FETCH_DEPTH];
    logic        read_rs_q   [FETCH_DEPTH];
    logic        read_rt_q   [FETCH_DEPTH];
    reg_addr_t   waddr_q     [FETCH_DEPTH];
    logic        mem_to_reg_q[FETCH_DEPTH];
    logic        is_div_q    [FETCH_DEPTH];
    pipe_event_t event_q     [FETCH_DEPTH];

    logic [$clog2(FETCH_DEPTH)-1:0]   wr_ptr;
    logic [$clog2(FETCH_DEPTH)-1:0]   rd_ptr;
    logic [$clog2(FETCH_DEPTH+1)-1:0] count;  // entries held
    logic push, pop;

    assign in_ready   = (count < FETCH_DEPTH);
    assign head_valid = (count != '0);
    assign push       = in_valid & in_ready;
    assign pop        = f_take & head_valid;  // never pop an empty queue

    // pointers and occupancy
    always_ff @(posedge clk) begin
        if (reset) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push) begin
                wr_ptr <= (wr_ptr == FETCH_DEPTH - 1) ? '0 : wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= (rd_ptr == FETCH_DEPTH - 1) ? '0 : rd_ptr + 1'b1;
            end
            if (push && !pop) begin
                count <= count + 1'b1;
            end else if (pop && !push) begin
                count <= count - 1'b1;
            end                                // push and pop together keep the count
        end
    end

    // payload written on push
    always_ff @(posedge clk) begin
        if (push) begin
            tag_q[wr_ptr]        <= in_tag;
            rs_q[wr_ptr]         <= in_rs;
            rt_q[wr_ptr]         <= in_rt;
            read_rs_q[wr_ptr]    <= in_read_rs;
            read_rt_q[wr_ptr]    <= in_read_rt;
            waddr_q[wr_ptr]      <= in_waddr;
            mem_to_reg_q[wr_ptr] <= in_mem_to_reg;
            is_div_q[wr_ptr]     <= in_is_div;
            event_q[wr_ptr]      <= in_event;
        end
    end

    // head shown combinationally
    assign head_tag        = tag_q[rd_ptr];
    assign head_rs         = rs_q[rd_ptr];
    assign head_rt         = rt_q[rd_ptr];
    assign head_read_rs    = read_rs_q[rd_ptr];
    assign head_read_rt    = read_rt_q[rd_ptr];
    assign head_waddr      = waddr_q[rd_ptr];
    assign head_mem_to_reg = mem_to_reg_q[rd_ptr];
    assign head_is_div     = is_div_q[rd_ptr];
    assign head_event      = event_q[rd_ptr];

endmodule

// ==== source/hazard_unit.sv ====
`timescale 1ns/100ps
module hazard_unit (
    // load-use check
    input  logic                      D_read_rs,
    input  logic                      D_read_rt,
    input  pipe_ctrl_pkg::reg_addr_t  D_rs,
    input  pipe_ctrl_pkg::reg_addr_t  D_rt,
    input  logic                      E_mem_to_reg,
    input  pipe_ctrl_pkg::reg_addr_t  E_waddr,
    // long stalls
    input  logic                      i_stall,
    input  logic                      d_stall,
    input  logic                      E_alu_stall,
    // events, later stage wins
    input  logic                      M_except,
    input  logic                      E_pred_fail,
    input  logic                      D_jump_take,
    // stage control
    output logic                      F_ena,
    output logic                      D_ena,
    output logic                      E_ena,
    output logic                      M_ena,
    output logic                      W_ena,
    output logic                      D_flush,
    output logic                      E_flush,
    output logic                      M_flush
);
    import pipe_ctrl_pkg::*;

    logic rs_match;       // D reads what the E load writes
    logic rt_match;
    logic lwstall;        // hold D, bubble into E
    logic longest_stall;  // freezes D..W

    assign rs_match = D_read_rs & (D_rs == E_waddr);
    assign rt_match = D_read_rt & (D_rt == E_waddr);

    // r0 writes are dropped, so no stall on them
    assign lwstall = E_mem_to_reg & (|E_waddr) & (rs_match | rt_match);

    assign longest_stall = i_stall | d_stall | E_alu_stall;

    // fetch side only cares about the icache, the buffer absorbs the rest
    assign F_ena = ~i_stall;
    assign D_ena = ~(lwstall | longest_stall);
    assign E_ena = ~longest_stall;         // load-use leaves E running
    assign M_ena = ~longest_stall;
    assign W_ena = ~longest_stall | M_except; // excepting instr still reaches W

    // flushes, each event clears every younger register
    assign D_flush = M_except | E_pred_fail | D_jump_take; // kills F
    assign E_flush = M_except | E_pred_fail;               // kills D
    assign M_flush = M_except;                             // kills E

endmodule

// ==== source/div_stall_fsm.sv ====
`timescale 1ns/100ps
module div_stall_fsm (
    input  logic clk,
    input  logic reset,
    input  logic E_div,        // valid divide sitting in E
    output logic E_alu_stall
);
    import pipe_ctrl_pkg::*;

    div_state_t state;
    div_state_t state_next;
    logic [$clog2(DIV_LATENCY)-1:0] busy_cnt;  // cycles spent in DIV_BUSY

    // first stall cycle comes from IDLE, BUSY supplies the other DIV_LATENCY-1
    always_comb begin
        state_next = state;
        unique case (state)
            DIV_IDLE: begin
                if (E_div) begin
                    state_next = DIV_BUSY;
                end
            end
            DIV_BUSY: begin
                if (busy_cnt == DIV_LATENCY - 2) begin
                    state_next = DIV_DONE;
                end
            end
            DIV_DONE: state_next = DIV_IDLE;  // divide leaves E here
            default:  state_next = DIV_IDLE;
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            state    <= DIV_IDLE;
            busy_cnt <= '0;
        end else begin
            state <= state_next;
            if (state == DIV_BUSY) begin
                busy_cnt <= busy_cnt + 1'b1;
            end else begin
                busy_cnt <= '0;
            end
        end
    end

    // stall from the very cycle the divide shows up in E
    assign E_alu_stall = (state == DIV_BUSY) | ((state == DIV_IDLE) & E_div);

endmodule

// ==== source/pipe_stage_regs.sv ====
`timescale 1ns/100ps
module pipe_stage_regs (
    input  logic                        clk,
    input  logic                        reset,
    // fetch buffer head
    input  logic                        head_valid,
    input  pipe_ctrl_pkg::inst_tag_t    head_tag,
    input  pipe_ctrl_pkg::reg_addr_t    head_rs,
    input  pipe_ctrl_pkg::reg_addr_t    head_rt,
    input  logic                        head_read_rs,
    input  logic                        head_read_rt,
    input  pipe_ctrl_pkg::reg_addr_t    head_waddr,
    input  logic                        head_mem_to_reg,
    input  logic                        head_is_div,
    input  pipe_ctrl_pkg::pipe_event_t  head_event,
    output logic                        f_take,
    // from hazard_unit
    input  logic                        F_ena,
    input  logic                        D_ena,
    input  logic                        E_ena,
    input  logic                        M_ena,
    input  logic                        W_ena,
    input  logic                        D_flush,
    input  logic                        E_flush,
    input  logic                        M_flush,
    // to hazard_unit
    output logic                        D_read_rs,
    output logic                        D_read_rt,
    output pipe_ctrl_pkg::reg_addr_t    D_rs,
    output pipe_ctrl_pkg::reg_addr_t    D_rt,
    output logic                        E_mem_to_reg,
    output pipe_ctrl_pkg::reg_addr_t    E_waddr,
    output logic                        D_jump_take,
    output logic                        E_pred_fail,
    output logic                        M_except,
    output logic                        E_div,
    // W contents
    output logic                        w_valid,
    output pipe_ctrl_pkg::inst_tag_t    w_tag,
    output logic                        w_except
);
    import pipe_ctrl_pkg::*;

    logic f_valid, d_valid, e_valid, m_valid;
    logic f_free;  // F content leaves this cycle, or F is empty

    // F payload
    inst_tag_t   f_tag;
    reg_addr_t   f_rs, f_rt, f_waddr;
    logic        f_read_rs, f_read_rt, f_mem_to_reg, f_is_div;
    pipe_event_t f_event;
    // D payload
    inst_tag_t   d_tag;
    reg_addr_t   d_rs, d_rt, d_waddr;
    logic        d_read_rs, d_read_rt, d_mem_to_reg, d_is_div;
    pipe_event_t d_event;
    // E and M payload
    inst_tag_t   e_tag, m_tag;
    reg_addr_t   e_waddr;
    logic        e_mem_to_reg, e_is_div;
    pipe_event_t e_event, m_event;

    // F->D needs D_ena, a D flush throws F away
    assign f_free = ~f_valid | D_ena | D_flush;
    assign f_take = F_ena & head_valid & f_free;

    // valid bits, bubbles come in through these
    always_ff @(posedge clk) begin
        if (reset) begin
            f_valid <= 1'b0;
            d_valid <= 1'b0;
            e_valid <= 1'b0;
            m_valid <= 1'b0;
            w_valid <= 1'b0;
        end else begin
            if (f_free) f_valid <= f_take;                             // empty buffer -> bubble
            if (D_ena | D_flush) d_valid <= f_valid & ~D_flush;
            if (E_ena | E_flush) e_valid <= d_valid & D_ena & ~E_flush; // load-use -> bubble
            if (M_ena | M_flush) m_valid <= e_valid & E_ena & ~M_flush;
            if (W_ena) w_valid <= m_valid;
        end
    end

    // payload follows the enables only
    always_ff @(posedge clk) begin
        if (f_take) begin
            f_tag        <= head_tag;
            f_rs         <= head_rs;
            f_rt         <= head_rt;
            f_read_rs    <= head_read_rs;
            f_read_rt    <= head_read_rt;
            f_waddr      <= head_waddr;
            f_mem_to_reg <= head_mem_to_reg;
            f_is_div     <= head_is_div;
            f_event      <= head_event;
        end
        if (D_ena) begin
            d_tag        <= f_tag;
            d_rs         <= f_rs;
            d_rt         <= f_rt;
            d_read_rs    <= f_read_rs;
            d_read_rt    <= f_read_rt;
            d_waddr      <= f_waddr;
            d_mem_to_reg <= f_mem_to_reg;
            d_is_div     <= f_is_div;
            d_event      <= f_event;
        end
        if (D_ena) begin  // D moving implies E moving
            e_tag        <= d_tag;
            e_waddr      <= d_waddr;
            e_mem_to_reg <= d_mem_to_reg;
            e_is_div     <= d_is_div;
            e_event      <= d_event;
        end
        if (E_ena) begin
            m_tag   <= e_tag;
            m_event <= e_event;
        end
        if (W_ena) begin
            w_tag    <= m_tag;
            w_except <= (m_event == EV_EXCEPT);
        end
    end

    // hazard view, bubbles never match
    assign D_read_rs    = d_valid & d_read_rs;
    assign D_read_rt    = d_valid & d_read_rt;
    assign D_rs         = d_rs;
    assign D_rt         = d_rt;
    assign E_mem_to_reg = e_valid & e_mem_to_reg;
    assign E_waddr      = e_waddr;
    assign E_div        = e_valid & e_is_div;

    // jump and mispredict fire as their instr leaves the stage, so a stall never kills them
    assign D_jump_take = d_valid & (d_event == EV_JUMP) & D_ena;
    assign E_pred_fail = e_valid & (e_event == EV_MISPRED) & E_ena;
    assign M_except    = m_valid & (m_event == EV_EXCEPT);  // W_ena is forced anyway

endmodule

// ==== source/retire_port.sv ====
`timescale 1ns/100ps
module retire_port (
    input  logic                          clk,
    input  logic                          reset,
    input  logic                          w_valid,
    input  pipe_ctrl_pkg::inst_tag_t      w_tag,
    input  logic                          w_except,
    input  logic                          W_ena,
    output logic                          retire_valid,
    output pipe_ctrl_pkg::inst_tag_t      retire_tag,
    output logic                          retire_except,
    output pipe_ctrl_pkg::retire_count_t  retire_count
);
    import pipe_ctrl_pkg::*;

    logic w_leaving;  // W instr moves out this cycle

    // a held W stays silent, so a stall cannot retire it twice
    assign w_leaving = w_valid & W_ena;

    always_ff @(posedge clk) begin
        if (reset) begin
            retire_valid <= 1'b0;
            retire_count <= '0;
        end else begin
            retire_valid <= w_leaving;
            if (w_leaving) begin
                retire_count <= retire_count + 1'b1;  // wraps at 16 bits
            end
        end
    end

    // report payload
    always_ff @(posedge clk) begin
        if (w_leaving) begin
            retire_tag    <= w_tag;
            retire_except <= w_except;
        end
    end

endmodule

// ==== source/pipe_ctrl_top.sv ====
`timescale 1ns/100ps
module pipe_ctrl_top (
    input  logic                          clk,
    input  logic                          reset,
    // descriptor stream
    input  logic                          in_valid,
    output logic                          in_ready,
    input  pipe_ctrl_pkg::inst_tag_t      in_tag,
    input  pipe_ctrl_pkg::reg_addr_t      in_rs,
    input  pipe_ctrl_pkg::reg_addr_t      in_rt,
    input  logic                          in_read_rs,
    input  logic                          in_read_rt,
    input  pipe_ctrl_pkg::reg_addr_t      in_waddr,
    input  logic                          in_mem_to_reg,
    input  logic                          in_is_div,
    input  pipe_ctrl_pkg::pipe_event_t    in_event,
    // cache stalls
    input  logic                          i_stall,
    input  logic                          d_stall,
    // retirement
    output logic                          retire_valid,
    output pipe_ctrl_pkg::inst_tag_t      retire_tag,
    output logic                          retire_except,
    output pipe_ctrl_pkg::retire_count_t  retire_count
);
    import pipe_ctrl_pkg::*;

    // buffer head
    logic        head_valid;
    inst_tag_t   head_tag;
    reg_addr_t   head_rs, head_rt, head_waddr;
    logic        head_read_rs, head_read_rt, head_mem_to_reg, head_is_div;
    pipe_event_t head_event;
    logic        f_take;

    // stage control
    logic F_ena, D_ena, E_ena, M_ena, W_ena;
    logic D_flush, E_flush, M_flush;

    // hazard inputs
    logic      D_read_rs, D_read_rt, E_mem_to_reg;
    reg_addr_t D_rs, D_rt, E_waddr;
    logic      D_jump_take, E_pred_fail, M_except;
    logic      E_div, E_alu_stall;

    // W towards retire
    logic      w_valid, w_except;
    inst_tag_t w_tag;

    // all port names line up with the nets above
    fetch_buffer fetch_buffer_inst (.*);

    pipe_stage_regs pipe_stage_regs_inst (.*);

    hazard_unit hazard_unit_inst (.*);

    div_stall_fsm div_stall_fsm_inst (.*);

    retire_port retire_port_inst (.*);

endmodule

// ==== testbench/pipe_ctrl_properties.sv ====
`timescale 1ns/100ps
module pipe_ctrl_properties (
    input logic                      clk,
    input logic                      reset,
    input logic                      D_read_rs,
    input logic                      D_read_rt,
    input pipe_ctrl_pkg::reg_addr_t  D_rs,
    input pipe_ctrl_pkg::reg_addr_t  D_rt,
    input logic                      E_mem_to_reg,
    input pipe_ctrl_pkg::reg_addr_t  E_waddr,
    input logic                      i_stall,
    input logic                      d_stall,
    input logic                      E_alu_stall,
    input logic                      M_except,
    input logic                      F_ena,
    input logic                      D_ena,
    input logic                      E_ena,
    input logic                      M_ena,
    input logic                      W_ena,
    input logic                      D_flush,
    input logic                      E_flush,
    input logic                      M_flush
);
    logic load_use;  // own view of the load-use hazard

    assign load_use = E_mem_to_reg & (E_waddr != 5'd0)
                    & ((D_read_rs & (D_rs == E_waddr)) | (D_read_rt & (D_rt == E_waddr)));

    // exception flushes every younger stage and still moves into W
    assert property (@(posedge clk) disable iff (reset)
        M_except |-> (D_flush && E_flush && M_flush && W_ena))
        else $error("exception without full flush");

    // younger stages hold only bubbles once the exception has left M
    assert property (@(posedge clk) disable iff (reset)
        M_except |=> (!M_except && !D_read_rs && !D_read_rt && !E_mem_to_reg))
        else $error("exception left a younger instruction in D, E or M");

    // load-use alone holds D but keeps E running
    assert property (@(posedge clk) disable iff (reset)
        (load_use && !i_stall && !d_stall && !E_alu_stall) |-> (E_ena && !D_ena))
        else $error("load-use stall lowered E_ena");

    // nothing holds in the first cycle after reset
    assert property (@(posedge clk) ($past(reset) && !reset) |->
        (F_ena && D_ena && E_ena && M_ena && W_ena))
        else $error("enable low in first cycle after reset");

endmodule

// the hazard unit ports are the nets of the same name in the top level
bind pipe_ctrl_top pipe_ctrl_properties hazard_props_inst (
    .clk(clk), .reset(reset),
    .D_read_rs(D_read_rs), .D_read_rt(D_read_rt), .D_rs(D_rs), .D_rt(D_rt),
    .E_mem_to_reg(E_mem_to_reg), .E_waddr(E_waddr),
    .i_stall(i_stall), .d_stall(d_stall), .E_alu_stall(E_alu_stall), .M_except(M_except),
    .F_ena(F_ena), .D_ena(D_ena), .E_ena(E_ena), .M_ena(M_ena), .W_ena(W_ena),
    .D_flush(D_flush), .E_flush(E_flush), .M_flush(M_flush)
);

// ==== testbench/pipe_ctrl_tb.sv ====
`timescale 1ns/100ps
module pipe_ctrl_tb;
    import pipe_ctrl_pkg::*;

    localparam int N_TOTAL = 131;  // descriptors over all tests
    localparam int TIMEOUT_CYCLES = N_TOTAL * (DIV_LATENCY + 8) + 200;
    localparam logic [31:0] SEED = 32'h3a9e_be2a;

    typedef struct packed {
        inst_tag_t   tag;
        reg_addr_t   rs;
        reg_addr_t   rt;
        logic        rrs;
        logic        rrt;
        reg_addr_t   waddr;
        logic        mem;
        logic        div;
        pipe_event_t ev;
    } desc_t;

    logic clk = 1'b0, reset = 1'b1;
    logic in_valid = 1'b0, in_ready;
    inst_tag_t in_tag = '0;
    reg_addr_t in_rs = '0, in_rt = '0, in_waddr = '0;
    logic in_read_rs = 1'b0, in_read_rt = 1'b0, in_mem_to_reg = 1'b0, in_is_div = 1'b0;
    pipe_event_t in_event = EV_NONE;
    logic i_stall = 1'b0, d_stall = 1'b0;
    logic retire_valid, retire_except;
    inst_tag_t retire_tag;
    retire_count_t retire_count;

    desc_t descs[$];                 // current test stream
    inst_tag_t exp_tag[$];
    logic exp_exc[$];
    int ret_cycles[$];               // cycle of each retirement in this test
    int cycle = 0, errors = 0, tests_run = 0, tests_failed = 0, test_err0 = 0;
    int accept_cycle = 0;
    logic [31:0] rnd = SEED, stall_rnd = SEED;
    logic stall_en = 1'b0;
    inst_tag_t next_tag = '0;
    retire_count_t survivors = '0;

    pipe_ctrl_top pipe_ctrl_top_inst (.*);

    always #(20) clk = ~clk;

    always @(posedge clk) begin
        cycle <= cycle + 1;
        if (cycle >= TIMEOUT_CYCLES) begin
            $display("timeout: pipeline stopped retiring after %0d cycles", cycle);
            $display("SOME TESTS FAILED");
            $finish;
        end
    end

    function automatic logic [31:0] lcg_next(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    function automatic int kill_span(input pipe_event_t ev);
        return (ev == EV_JUMP) ? 1 : (ev == EV_MISPRED) ? 2 : (ev == EV_EXCEPT) ? 3 : 0;
    endfunction

    // survives unless an older live event covers it
    function automatic bit expected_retire(input int idx);
        int kill;
        kill = 0;
        for (int j = 0; j < idx; j++) begin
            if (kill > 0) kill--;            // killed instr raises no event
            else kill = kill_span(descs[j].ev);
        end
        return kill == 0;
    endfunction

    task automatic check_tag(input string name, input inst_tag_t got, input inst_tag_t exp);
        if (got !== exp) begin
            $display("mismatch at %0t: %s got %h expected %h", $time, name, got, exp);
            errors++;
        end
    endtask

    task automatic check_flag(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            $display("mismatch at %0t: %s got %b expected %b", $time, name, got, exp);
            errors++;
        end
    endtask

    task automatic check_count(input string name, input retire_count_t got,
                               input retire_count_t exp);
        if (got !== exp) begin
            $display("mismatch at %0t: %s got %0d expected %0d", $time, name, got, exp);
            errors++;
        end
    endtask

    // compare every retirement with the next expected survivor
    always @(negedge clk) begin
        if (!reset && retire_valid) begin
            if (exp_tag.size() == 0) begin
                $display("unexpected retirement of tag %h at %0t", retire_tag, $time);
                errors++;
            end else begin
                check_tag("retire_tag", retire_tag, exp_tag.pop_front());
                check_flag("retire_except", retire_except, exp_exc.pop_front());
            end
            ret_cycles.push_back(cycle);
        end
    end

    // random cache stall pulses while stall_en is set
    always @(posedge clk) begin
        #2;
        if (stall_en) begin
            stall_rnd = lcg_next(stall_rnd);
            i_stall = (stall_rnd[31:28] < 4'd3);
            d_stall = (stall_rnd[27:24] < 4'd3);
        end else begin
            i_stall = 1'b0;
            d_stall = 1'b0;
        end
    end

    task automatic add_desc(input reg_addr_t rs, input reg_addr_t rt, input logic rrs,
                            input logic rrt, input reg_addr_t waddr, input logic mem,
                            input logic div, input pipe_event_t ev);
        descs.push_back({next_tag, rs, rt, rrs, rrt, waddr, mem, div, ev});
        next_tag++;
    endtask

    // queue expected survivors then feed the stream with optional idle cycles
    task automatic issue_all(input bit idle_gaps);
        ret_cycles.delete();
        for (int i = 0; i < descs.size(); i++) begin
            if (expected_retire(i)) begin
                exp_tag.push_back(descs[i].tag);
                exp_exc.push_back(descs[i].ev == EV_EXCEPT);
                survivors++;
            end
        end
        foreach (descs[i]) begin
            if (idle_gaps) begin
                rnd = lcg_next(rnd);
                repeat (int'(rnd[31:30])) begin
                    @(posedge clk);
                    #2;
                end
            end
            {in_tag, in_rs, in_rt, in_read_rs, in_read_rt, in_waddr,
             in_mem_to_reg, in_is_div, in_event} = descs[i];
            in_valid = 1'b1;
            @(negedge clk);
            while (!in_ready) @(negedge clk);  // held stable until taken
            accept_cycle = cycle + 1;
            @(posedge clk);
            #2;
            in_valid = 1'b0;
        end
        descs.delete();
    endtask

    task automatic drain_and_report(input string name);
        while (exp_tag.size() != 0) @(negedge clk);
        repeat (4) @(negedge clk);  // catch stray retirements
        check_count("retire_count", retire_count, survivors);
        tests_run++;
        if (errors == test_err0) $display("test %s: ok", name);
        else begin
            $display("test %s: %0d errors", name, errors - test_err0);
            tests_failed++;
        end
        test_err0 = errors;
        @(posedge clk);
        #2;
    endtask

    function automatic int largest_gap();
        int g;
        g = 0;
        for (int i = 1; i < ret_cycles.size(); i++)
            if (ret_cycles[i] - ret_cycles[i-1] > g) g = ret_cycles[i] - ret_cycles[i-1];
        return g;
    endfunction

    initial begin
        repeat (5) @(posedge clk);
        #2;
        reset = 1'b0;
        @(negedge clk);
        check_flag("in_ready", in_ready, 1'b1);
        check_flag("retire_valid", retire_valid, 1'b0);
        @(posedge clk);
        #2;

        // 1 lone latency and a plain stream
        add_desc(5'd1, 5'd2, 1'b0, 1'b0, 5'd3, 1'b0, 1'b0, EV_NONE);
        issue_all(1'b0);
        while (exp_tag.size() != 0) @(negedge clk);
        if (ret_cycles[0] - accept_cycle != RETIRE_LATENCY) begin
            $display("lone descriptor retired %0d edges after acceptance, not %0d",
                     ret_cycles[0] - accept_cycle, RETIRE_LATENCY);
            errors++;
        end
        @(posedge clk);
        #2;
        for (int i = 0; i < 40; i++) add_desc(5'd1, 5'd2, 1'b0, 1'b0, 5'd4, 1'b0, 1'b0, EV_NONE);
        issue_all(1'b0);
        drain_and_report("hazard free");

        // 2 load-use on r5 leaves a hole but r0 does not
        add_desc(5'd0, 5'd0, 1'b0, 1'b0, 5'd5, 1'b1, 1'b0, EV_NONE);
        add_desc(5'd5, 5'd6, 1'b1, 1'b0, 5'd7, 1'b0, 1'b0, EV_NONE);
        issue_all(1'b0);
        while (exp_tag.size() != 0) @(negedge clk);
        if (ret_cycles[1] - ret_cycles[0] < 2) begin
            $display("load-use on r5 produced no retire gap");
            errors++;
        end
        @(posedge clk);
        #2;
        add_desc(5'd0, 5'd0, 1'b0, 1'b0, 5'd0, 1'b1, 1'b0, EV_NONE);
        add_desc(5'd3, 5'd0, 1'b0, 1'b1, 5'd8, 1'b0, 1'b0, EV_NONE);
        add_desc(5'd0, 5'd0, 1'b1, 1'b0, 5'd9, 1'b0, 1'b0, EV_NONE);
        issue_all(1'b0);
        while (exp_tag.size() != 0) @(negedge clk);
        if (largest_gap() != 1) begin
            $display("dependency on r0 stalled the pipeline");
            errors++;
        end
        drain_and_report("load-use");

        // 3 control events without loads so no bubble lands in a kill window
        for (int i = 0; i < 40; i++) begin
            rnd = lcg_next(rnd);
            add_desc(rnd[20:16], rnd[12:8], rnd[15], rnd[7], rnd[4:0], 1'b0, 1'b0,
                     (rnd[31:30] == 2'd0) ? rnd[29:28] : EV_NONE);
        end
        issue_all(1'b0);
        drain_and_report("events");

        // 4 divide holds the back end for DIV_LATENCY cycles
        for (int i = 0; i < 5; i++)
            add_desc(5'd1, 5'd2, 1'b0, 1'b0, 5'd3, 1'b0, (i == 3), EV_NONE);
        issue_all(1'b0);
        while (exp_tag.size() != 0) @(negedge clk);
        if (largest_gap() < DIV_LATENCY + 1) begin
            $display("divide left only %0d idle retire cycles", largest_gap() - 1);
            errors++;
        end
        drain_and_report("divide");

        // 5 random stalls and a lazy source change timing only
        stall_en = 1'b1;
        for (int i = 0; i < 40; i++) begin
            rnd = lcg_next(rnd);
            add_desc({2'b00, rnd[20:18]}, {2'b00, rnd[17:15]}, rnd[31], rnd[30],
                     {2'b00, rnd[14:12]}, rnd[29], (rnd[27:24] == 4'd0), EV_NONE);
        end
        issue_all(1'b1);
        stall_en = 1'b0;
        drain_and_report("random stalls");

        $display("tests run %0d, failed %0d, errors %0d", tests_run, tests_failed, errors);
        if (errors == 0) $display("ALL TESTS PASSED");
        else $display("SOME TESTS FAILED");
        $finish;
    end

endmodule

// ==== vlog.f ====
source/pipe_ctrl_pkg.sv
source/fetch_buffer.sv
source/hazard_unit.sv
source/div_stall_fsm.sv
source/pipe_stage_regs.sv
source/retire_port.sv
source/pipe_ctrl_top.sv
testbench/pipe_ctrl_properties.sv
testbench/pipe_ctrl_tb.sv

// ==== run.sh ====
#!/usr/bin/env bash
# build and run the pipeline control testbench with Verilator
set -u
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
    --top-module pipe_ctrl_tb -f vlog.f -o pipe_ctrl_sim > build.log 2>&1
if [ $? -ne 0 ]; then
    echo "build failed, see build.log"
    exit 1
fi

./obj_dir/pipe_ctrl_sim > sim.log 2>&1
sim_status=$?
cat sim.log
if [ $sim_status -ne 0 ]; then
    echo "simulation exited with status $sim_status"
    exit 1
fi

if grep -q "SOME TESTS FAILED" sim.log; then
    exit 1
fi
if ! grep -q "ALL TESTS PASSED" sim.log; then
    echo "simulation ended without a verdict"
    exit 1
fi
exit 0
